// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = ddr3_model_tb
FILELIST  = ddr3_model_top.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: ddr3_model_top.f
+incdir+design
design/ddr3_cmd_pkg.sv
design/ddr3_mem_pkg.sv
design/ddr3_cmd_decode.sv
design/ddr3_latency_line.sv
design/ddr3_write_burst.sv
design/ddr3_read_burst.sv
design/ddr3_store.sv
design/ddr3_model_top.sv
verification/ddr3_model_assertions.sv
verification/ddr3_model_tb.sv

// File: design/ddr3_cmd_decode.sv
// DDR3 command decoder
`timescale 1ns/100ps
`include "ddr3_model_cfg.svh"

module ddr3_cmd_decode
(
	input  logic                     cont_if_mem_model,
	input  logic                     rst_n,
	input  logic                     cs_n,
	input  logic                     ras_n,
	input  logic                     cas_n,
	input  logic                     we_n,
	input  ddr3_cmd_pkg::bank_t      ba,
	input  ddr3_cmd_pkg::row_t       addr,
	output logic                     rd_req,
	output logic                     wr_req,
	output ddr3_mem_pkg::mem_addr_t  rd_addr,
	output ddr3_mem_pkg::mem_addr_t  wr_addr
);
	import ddr3_cmd_pkg::*;

	ddr_cmd_e cmd;
	col_t     col;
	row_t     open_row [2**`DDR_BA_WIDTH]; // one open row per bank

	// deselect whenever chip select is high
	always_comb
	begin
		if (cs_n)
			cmd = DES;
		else
			cmd = ddr_cmd_e'({1'b0, ras_n, cas_n, we_n});
	end

	assign col = addr[`DDR_COL_WIDTH-1:0]; // column in the low address bits

	always_ff @(posedge cont_if_mem_model)
	begin
		if (cmd == ACTIVATE)
			open_row[ba] <= addr;
	end

	// request pulses, everything but READ and WRITE ends up here as no request
	always_ff @(posedge cont_if_mem_model)
	begin
		if (!rst_n)
		begin
			rd_req <= 1'b0;
			wr_req <= 1'b0;
		end
		else
		begin
			rd_req <= (cmd == READ);
			wr_req <= (cmd == WRITE);
		end
	end

	always_ff @(posedge cont_if_mem_model)
	begin
		if (cmd == READ)
			rd_addr <= {ba, open_row[ba], col};
		if (cmd == WRITE)
			wr_addr <= {ba, open_row[ba], col};
	end

endmodule

// File: design/ddr3_cmd_pkg.sv
// DDR3 command encodings
`include "ddr3_model_cfg.svh"

package ddr3_cmd_pkg;

	// {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0]
	{
		MRS       = 4'b0000,
		REFRESH   = 4'b0001,
		PRECHARGE = 4'b0010,
		ACTIVATE  = 4'b0011,
		WRITE     = 4'b0100,
		READ      = 4'b0101,
		ZQC       = 4'b0110,
		NOP       = 4'b0111,
		DES       = 4'b1000 // any code with cs_n high
	} ddr_cmd_e;

	typedef logic [`DDR_BA_WIDTH-1:0]  bank_t;
	typedef logic [`DDR_ROW_WIDTH-1:0] row_t;
	typedef logic [`DDR_COL_WIDTH-1:0] col_t;

endpackage

// File: design/ddr3_latency_line.sv
// request delay line
`timescale 1ns/100ps

module ddr3_latency_line
#(
	parameter int DEPTH = 1
)
(
	input  logic                     cont_if_mem_model,
	input  logic                     rst_n,
	input  logic                     in_req,
	input  ddr3_mem_pkg::mem_addr_t  in_addr,
	output logic                     out_req,
	output ddr3_mem_pkg::mem_addr_t  out_addr
);
	import ddr3_mem_pkg::*;

	logic      req_sr  [DEPTH];
	mem_addr_t addr_sr [DEPTH];

	always_ff @(posedge cont_if_mem_model)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < DEPTH; i++)
				req_sr[i] <= 1'b0;
		end
		else
		begin
			req_sr[0] <= in_req;
			for (int i = 1; i < DEPTH; i++)
				req_sr[i] <= req_sr[i-1];
		end
	end

	// addresses just follow along
	always_ff @(posedge cont_if_mem_model)
	begin
		addr_sr[0] <= in_addr;
		for (int i = 1; i < DEPTH; i++)
			addr_sr[i] <= addr_sr[i-1];
	end

	assign out_req  = req_sr[DEPTH-1];
	assign out_addr = addr_sr[DEPTH-1];

endmodule

// File: design/ddr3_mem_pkg.sv
// DDR3 model datapath types
`include "ddr3_model_cfg.svh"

package ddr3_mem_pkg;

	// flat store address {bank, row, column}
	typedef logic [`DDR_BA_WIDTH+`DDR_ROW_WIDTH+`DDR_COL_WIDTH-1:0] mem_addr_t;

	// one beat, lane 1 in the upper byte
	typedef logic [`DDR_LANES*`DDR_DQ_WIDTH-1:0] beat_t;

	typedef logic [`DDR_LANES-1:0] lane_en_t;

	// low two bits of the burst states give the beat index
	typedef enum logic [2:0]
	{
		WR_IDLE = 3'd4,
		WR_D0   = 3'd0,
		WR_D1   = 3'd1,
		WR_D2   = 3'd2,
		WR_D3   = 3'd3
	} wr_state_e;

	typedef enum logic [2:0]
	{
		RD_IDLE = 3'd4,
		RD_D0   = 3'd0,
		RD_D1   = 3'd1,
		RD_D2   = 3'd2,
		RD_D3   = 3'd3
	} rd_state_e;

endpackage

// File: design/ddr3_model_cfg.svh
// DDR3 model sizes and latencies
`ifndef DDR3_MODEL_CFG_SVH
`define DDR3_MODEL_CFG_SVH

// data path
`define DDR_DQ_WIDTH   8
`define DDR_LANES      2

// address fields, cut down so the store fits in simulation
`define DDR_BA_WIDTH   2
`define DDR_ROW_WIDTH  6
`define DDR_COL_WIDTH  6

// latencies in clock cycles
`define DDR_AL         3
`define DDR_CL         5
`define DDR_CWL        5
`define DDR_RL         (`DDR_CL + `DDR_AL)
`define DDR_WL         (`DDR_CWL + `DDR_AL)

`define DDR_BURST_LEN  4

`endif

// File: design/ddr3_model_top.sv
// DDR3 memory model top level
`timescale 1ns/100ps
`include "ddr3_model_cfg.svh"

module ddr3_model_top
(
	input  logic                     cont_if_mem_model,
	input  logic                     rst_n,
	input  logic                     cs_n,
	input  logic                     ras_n,
	input  logic                     cas_n,
	input  logic                     we_n,
	input  ddr3_cmd_pkg::bank_t      ba,
	input  ddr3_cmd_pkg::row_t       addr,
	input  ddr3_mem_pkg::beat_t      wr_data,
	input  ddr3_mem_pkg::lane_en_t   wr_byte_en,
	output ddr3_mem_pkg::beat_t      rd_data,
	output logic                     rd_valid
);
	import ddr3_mem_pkg::*;

	logic      rd_req;         // from decoder, one cycle after the command
	logic      wr_req;
	mem_addr_t rd_addr;
	mem_addr_t wr_addr;
	logic      rd_req_dly;     // after the latency lines
	logic      wr_req_dly;
	mem_addr_t rd_addr_dly;
	mem_addr_t wr_addr_dly;
	logic      store_we;
	mem_addr_t store_waddr;
	mem_addr_t store_raddr;

	ddr3_cmd_decode ddr3_cmd_decode_i
	(
		.cont_if_mem_model (cont_if_mem_model),
		.rst_n             (rst_n),
		.cs_n              (cs_n),
		.ras_n             (ras_n),
		.cas_n             (cas_n),
		.we_n              (we_n),
		.ba                (ba),
		.addr              (addr),
		.rd_req            (rd_req),
		.wr_req            (wr_req),
		.rd_addr           (rd_addr),
		.wr_addr           (wr_addr)
	);

	// decoder and burst engine each take one cycle of the latency
	ddr3_latency_line #(.DEPTH(`DDR_WL - 2)) wr_line_i
	(
		.cont_if_mem_model (cont_if_mem_model),
		.rst_n             (rst_n),
		.in_req            (wr_req),
		.in_addr           (wr_addr),
		.out_req           (wr_req_dly),
		.out_addr          (wr_addr_dly)
	);

	ddr3_latency_line #(.DEPTH(`DDR_RL - 2)) rd_line_i
	(
		.cont_if_mem_model (cont_if_mem_model),
		.rst_n             (rst_n),
		.in_req            (rd_req),
		.in_addr           (rd_addr),
		.out_req           (rd_req_dly),
		.out_addr          (rd_addr_dly)
	);

	ddr3_write_burst ddr3_write_burst_i
	(
		.cont_if_mem_model (cont_if_mem_model),
		.rst_n             (rst_n),
		.req               (wr_req_dly),
		.base_addr         (wr_addr_dly),
		.we                (store_we),
		.waddr             (store_waddr)
	);

	ddr3_read_burst ddr3_read_burst_i
	(
		.cont_if_mem_model (cont_if_mem_model),
		.rst_n             (rst_n),
		.req               (rd_req_dly),
		.base_addr         (rd_addr_dly),
		.raddr             (store_raddr),
		.rd_valid          (rd_valid)
	);

	ddr3_store ddr3_store_i
	(
		.cont_if_mem_model (cont_if_mem_model),
		.we                (store_we),
		.waddr             (store_waddr),
		.wr_data           (wr_data),
		.wr_byte_en        (wr_byte_en),
		.raddr             (store_raddr),
		.rd_data           (rd_data)
	);

endmodule

// File: design/ddr3_read_burst.sv
// read burst sequencer
`timescale 1ns/100ps

module ddr3_read_burst
(
	input  logic                     cont_if_mem_model,
	input  logic                     rst_n,
	input  logic                     req,
	input  ddr3_mem_pkg::mem_addr_t  base_addr,
	output ddr3_mem_pkg::mem_addr_t  raddr,
	output logic                     rd_valid
);
	import ddr3_mem_pkg::*;

	rd_state_e state;
	mem_addr_t base_q;
	logic [1:0] beat_idx;

	always_ff @(posedge cont_if_mem_model)
	begin
		if (!rst_n)
		begin
			state    <= RD_IDLE;
			rd_valid <= 1'b0;
		end
		else
		begin
			rd_valid <= (state != RD_IDLE); // lines up with the store output register
			case (state)
				RD_IDLE: if (req) state <= RD_D0;
				RD_D0:   state <= RD_D1;
				RD_D1:   state <= RD_D2;
				RD_D2:   state <= RD_D3;
				RD_D3:   state <= req ? RD_D0 : RD_IDLE;
				default: state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge cont_if_mem_model)
	begin
		if (req && (state == RD_IDLE || state == RD_D3))
			base_q <= base_addr;
	end

	// beat offset from the state
	always_comb
	begin
		case (state)
			RD_D1:   beat_idx = 2'd1;
			RD_D2:   beat_idx = 2'd2;
			RD_D3:   beat_idx = 2'd3;
			default: beat_idx = 2'd0;
		endcase
	end

	assign raddr = base_q + mem_addr_t'(beat_idx);

endmodule

// File: design/ddr3_store.sv
// two-lane dual-port store
`timescale 1ns/100ps
`include "ddr3_model_cfg.svh"

module ddr3_store
(
	input  logic                     cont_if_mem_model,
	input  logic                     we,
	input  ddr3_mem_pkg::mem_addr_t  waddr,
	input  ddr3_mem_pkg::beat_t      wr_data,
	input  ddr3_mem_pkg::lane_en_t   wr_byte_en,
	input  ddr3_mem_pkg::mem_addr_t  raddr,
	output ddr3_mem_pkg::beat_t      rd_data
);
	import ddr3_mem_pkg::*;

	localparam int DEPTH = 2**$bits(mem_addr_t);

	for (genvar l = 0; l < `DDR_LANES; l++)
	begin : g_lane
		logic [`DDR_DQ_WIDTH-1:0] mem [DEPTH];

		always_ff @(posedge cont_if_mem_model)
		begin
			if (we && wr_byte_en[l])
				mem[waddr] <= wr_data[l*`DDR_DQ_WIDTH +: `DDR_DQ_WIDTH];
		end

		// registered read
		always_ff @(posedge cont_if_mem_model)
		begin
			rd_data[l*`DDR_DQ_WIDTH +: `DDR_DQ_WIDTH] <= mem[raddr];
		end
	end

endmodule

// File: design/ddr3_write_burst.sv
// write burst sequencer
`timescale 1ns/100ps

module ddr3_write_burst
(
	input  logic                     cont_if_mem_model,
	input  logic                     rst_n,
	input  logic                     req,
	input  ddr3_mem_pkg::mem_addr_t  base_addr,
	output logic                     we,
	output ddr3_mem_pkg::mem_addr_t  waddr
);
	import ddr3_mem_pkg::*;

	wr_state_e state;
	mem_addr_t base_q;
	logic [1:0] beat_idx;

	always_ff @(posedge cont_if_mem_model)
	begin
		if (!rst_n)
			state <= WR_IDLE;
		else
		begin
			case (state)
				WR_IDLE: if (req) state <= WR_D0;
				WR_D0:   state <= WR_D1;
				WR_D1:   state <= WR_D2;
				WR_D2:   state <= WR_D3;
				WR_D3:   state <= req ? WR_D0 : WR_IDLE; // back to back burst
				default: state <= WR_IDLE;
			endcase
		end
	end

	// base address latched at burst start
	always_ff @(posedge cont_if_mem_model)
	begin
		if (req && (state == WR_IDLE || state == WR_D3))
			base_q <= base_addr;
	end

	always_comb
	begin
		case (state)
			WR_D1:   beat_idx = 2'd1;
			WR_D2:   beat_idx = 2'd2;
			WR_D3:   beat_idx = 2'd3;
			default: beat_idx = 2'd0;
		endcase
	end

	assign we    = (state != WR_IDLE);
	assign waddr = base_q + mem_addr_t'(beat_idx); // carry runs into row and bank

endmodule

// File: verification/ddr3_model_assertions.sv
// read path checks on the model top
`timescale 1ns/100ps
`include "ddr3_model_cfg.svh"

module ddr3_model_assertions
(
	input logic cont_if_mem_model,
	input logic rst_n,
	input logic rd_req,
	input logic rd_valid
);

	// valid register clears with reset
	a_valid_low_after_reset : assert property
		(@(posedge cont_if_mem_model) !rst_n |=> !rd_valid)
		else $error("rd_valid high in the cycle after reset");

	// four valid beats, the first sampled RL edges after the request
	a_read_burst_valid : assert property
		(@(posedge cont_if_mem_model) disable iff (!rst_n)
		($past(rd_req, `DDR_RL) || $past(rd_req, `DDR_RL + 1) ||
		$past(rd_req, `DDR_RL + 2) || $past(rd_req, `DDR_RL + 3)) |-> rd_valid)
		else $error("rd_valid missing during a read burst");

endmodule

bind ddr3_model_top ddr3_model_assertions ddr3_model_assertions_i
(
	.cont_if_mem_model (cont_if_mem_model),
	.rst_n             (rst_n),
	.rd_req            (rd_req),
	.rd_valid          (rd_valid)
);

// File: verification/ddr3_model_tb.sv
// DDR3 memory model testbench
`timescale 1ns/100ps
`include "ddr3_model_cfg.svh"

module ddr3_model_tb;
	import ddr3_cmd_pkg::*;
	import ddr3_mem_pkg::*;

	localparam int MEM_DEPTH   = 2**$bits(mem_addr_t);
	localparam int LW          = `DDR_DQ_WIDTH;
	localparam int DRAIN_LIMIT = 64; // cycles to wait for outstanding read beats

	logic     cont_if_mem_model;
	logic     rst_n;
	logic     cs_n;
	logic     ras_n;
	logic     cas_n;
	logic     we_n;
	bank_t    ba;
	row_t     addr;
	beat_t    wr_data = '0;
	lane_en_t wr_byte_en = '0;
	beat_t    rd_data;
	logic     rd_valid;

	beat_t               ref_mem   [MEM_DEPTH];
	bit [`DDR_LANES-1:0] ref_known [MEM_DEPTH]; // lanes written so far
	row_t                ref_row   [2**`DDR_BA_WIDTH];

	beat_t    exp_q   [$];
	beat_t    mask_q  [$];
	int       edge_q  [$];
	int       wq_edge [$]; // write beats waiting for their edge
	beat_t    wq_data [$];
	lane_en_t wq_en   [$];

	int       edge_cnt = 0;
	int       checks = 0;
	int       errors = 0;
	beat_t    cmp_beat;
	beat_t    cmp_mask;
	int       cmp_edge;

	ddr3_model_top ddr3_model_top_i (.*);

	always #10 cont_if_mem_model = ~cont_if_mem_model;

	always @(posedge cont_if_mem_model)
		edge_cnt <= edge_cnt + 1;

	// enabled lanes take the new byte
	function automatic beat_t merge_beat(beat_t old_beat, beat_t new_beat, lane_en_t en);
		beat_t res;
		res = old_beat;
		for (int l = 0; l < `DDR_LANES; l++)
			if (en[l])
				res[l*LW +: LW] = new_beat[l*LW +: LW];
		return res;
	endfunction

	function automatic beat_t lane_mask(mem_addr_t a);
		beat_t m;
		for (int l = 0; l < `DDR_LANES; l++)
			m[l*LW +: LW] = {LW{ref_known[a][l]}};
		return m;
	endfunction

	// beat k address with carry into row and bank
	function automatic mem_addr_t burst_addr(bank_t b, col_t c, int k);
		return {b, ref_row[b], c} + mem_addr_t'(k);
	endfunction

	task automatic step();
		@(posedge cont_if_mem_model);
		#2;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
			step();
	endtask

	task automatic issue_cmd(input ddr_cmd_e c, input bank_t b, input row_t a);
		{cs_n, ras_n, cas_n, we_n} = c;
		ba   = b;
		addr = a;
		step();
		{cs_n, ras_n, cas_n, we_n} = NOP; // idle pins between commands
	endtask

	task automatic activate(input bank_t b, input row_t r);
		ref_row[b] = r;
		issue_cmd(ACTIVATE, b, r);
	endtask

	// beat k sits in data[16k +: 16] and its lane enables in ens[2k +: 2]
	task automatic issue_write(input bank_t b, input col_t c, input logic [63:0] data,
		input logic [7:0] ens);
		int        t0;
		mem_addr_t a;
		t0 = edge_cnt + 1;
		for (int k = 0; k < `DDR_BURST_LEN; k++)
		begin
			a = burst_addr(b, c, k);
			ref_mem[a]   = merge_beat(ref_mem[a], data[k*16 +: 16], ens[k*2 +: 2]);
			ref_known[a] = ref_known[a] | ens[k*2 +: 2];
			wq_edge.push_back(t0 + `DDR_WL + k);
			wq_data.push_back(data[k*16 +: 16]);
			wq_en.push_back(ens[k*2 +: 2]);
		end
		issue_cmd(WRITE, b, row_t'(c));
	endtask

	task automatic issue_read(input bank_t b, input col_t c);
		int        t0;
		mem_addr_t a;
		t0 = edge_cnt + 1;
		for (int k = 0; k < `DDR_BURST_LEN; k++)
		begin
			a = burst_addr(b, c, k);
			exp_q.push_back(ref_mem[a]);
			mask_q.push_back(lane_mask(a));
			edge_q.push_back(t0 + `DDR_RL + k);
		end
		issue_cmd(READ, b, row_t'(c));
	endtask

	task automatic wait_reads_done();
		int cnt;
		cnt = 0;
		while (exp_q.size() > 0 && cnt < DRAIN_LIMIT)
		begin
			step();
			cnt++;
		end
		if (exp_q.size() > 0)
		begin
			$display("timeout waiting for rd_valid, %0d read beats still outstanding",
				exp_q.size());
			errors++;
		end
	endtask

	// beat k is driven one cycle before the edge t0+WL+k
	always @(posedge cont_if_mem_model)
	begin
		#2;
		if (wq_edge.size() > 0 && wq_edge[0] == edge_cnt + 1)
		begin
			wr_data    = wq_data.pop_front();
			wr_byte_en = wq_en.pop_front();
			wq_edge.delete(0);
		end
		else
		begin
			wr_data    = '0;
			wr_byte_en = '0;
		end
	end

	always @(negedge cont_if_mem_model)
	begin
		if (rd_valid === 1'b1)
		begin
			assert (exp_q.size() > 0)
			else
			begin
				$display("rd_valid high at edge %0d with no read outstanding", edge_cnt);
				errors++;
			end
			if (exp_q.size() > 0)
			begin
				cmp_beat = exp_q.pop_front();
				cmp_mask = mask_q.pop_front();
				cmp_edge = edge_q.pop_front();
				checks++;
				assert ((rd_data & cmp_mask) === (cmp_beat & cmp_mask))
				else
				begin
					$display("FAIL rd_data expected %h actual %h", cmp_beat & cmp_mask,
						rd_data & cmp_mask);
					errors++;
				end
				assert (edge_cnt == cmp_edge)
				else
				begin
					$display("FAIL rd_valid edge expected %h actual %h", cmp_edge, edge_cnt);
					errors++;
				end
			end
		end
	end

	initial
	begin
		bank_t rb [4];
		col_t  rc [4];
		void'($urandom(38485));
		cont_if_mem_model = 1'b0;
		rst_n = 1'b0;
		{cs_n, ras_n, cas_n, we_n} = NOP;
		ba   = '0;
		addr = '0;
		repeat (3)
			@(posedge cont_if_mem_model);
		#2;
		rst_n = 1'b1;

		idle_cycles(20); // no beats may appear here

		// single burst on both lanes
		activate(2'd0, 6'd5);
		issue_write(2'd0, 6'd8, 64'h4444_3333_2222_1111, 8'hff);
		idle_cycles(3);
		issue_read(2'd0, 6'd8);
		idle_cycles(3);
		wait_reads_done();

		// partial overwrite keeps old bytes
		issue_write(2'd0, 6'd8, 64'hdddd_cccc_bbbb_aaaa, 8'b11_00_10_01);
		idle_cycles(3);
		issue_read(2'd0, 6'd8);
		idle_cycles(3);
		wait_reads_done();

		// per-bank open rows and row carry
		activate(2'd1, 6'd9);
		issue_write(2'd1, 6'd10, 64'h1919_1818_1717_1616, 8'hff);
		idle_cycles(3);
		issue_write(2'd0, 6'd62, 64'h6e6e_6d6d_6c6c_6b6b, 8'hff);
		idle_cycles(3);
		activate(2'd1, 6'd20);
		issue_write(2'd1, 6'd10, 64'h2727_2626_2525_2424, 8'hff);
		idle_cycles(3);
		issue_read(2'd1, 6'd10);
		idle_cycles(3);
		issue_read(2'd0, 6'd62);
		idle_cycles(3);
		activate(2'd1, 6'd9);
		issue_read(2'd1, 6'd10);
		idle_cycles(3);
		wait_reads_done();
		activate(2'd0, 6'd63); // last row carries into bank 1
		issue_write(2'd0, 6'd63, 64'h8888_7777_6666_5555, 8'hff);
		idle_cycles(3);
		issue_read(2'd0, 6'd63);
		idle_cycles(3);
		wait_reads_done();

		// seamless reads with ignored commands in the gaps
		issue_read(2'd1, 6'd10);
		issue_cmd(PRECHARGE, 2'd1, '0);
		issue_cmd(REFRESH, '0, '0);
		issue_cmd(ZQC, '0, '0);
		issue_read(2'd0, 6'd62);
		issue_cmd(MRS, '0, '0);
		issue_cmd(DES, '0, '0);
		idle_cycles(1);
		wait_reads_done();

		for (int r = 0; r < 8; r++)
		begin
			for (int b = 0; b < 4; b++)
				activate(bank_t'(b), row_t'($urandom()));
			for (int w = 0; w < 4; w++)
			begin
				rb[w] = bank_t'($urandom());
				rc[w] = col_t'($urandom());
				issue_write(rb[w], rc[w], {$urandom(), $urandom()}, 8'($urandom()));
				idle_cycles(3 + int'($urandom_range(0, 2)));
			end
			idle_cycles(4);
			for (int w = 0; w < 4; w++)
			begin
				issue_read(rb[w], rc[w]);
				idle_cycles(3);
			end
			wait_reads_done();
		end

		idle_cycles(4);
		assert (exp_q.size() == 0)
		else
		begin
			$display("%0d expected read beats left over at the end", exp_q.size());
			errors += exp_q.size();
		end
		$display("beats checked %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
